/* tinker_cfg.svh */
// Core constants. TINKER_DMEM_WORDS must be a power of two because data addresses wrap on it
`ifndef TINKER_CFG_SVH
`define TINKER_CFG_SVH

`define TINKER_XLEN        64          // Data word width
`define TINKER_AW          32          // PC and address width
`define TINKER_NREGS       32
`define TINKER_RESET_PC    32'h2000
`define TINKER_STACK_INIT  64'h10000   // r31 after reset

// Depth in 64-bit words
`define TINKER_DMEM_WORDS  512

`endif

/* tinker_isa_pkg.sv */
// Opcode encodings and field types for the integer subset of Tinker without div, call or return
package tinker_isa_pkg;

    // Opcode sits in bits 31:27
    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,   // rt ignored
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08,   // pc = rd
        OP_BRR_R  = 5'h09,   // pc += rd
        OP_BRR_L  = 5'h0a,   // pc += sext(L)
        OP_BRNZ   = 5'h0b,
        OP_BRGT   = 5'h0e,
        OP_LOAD   = 5'h10,   // mov rd, (rs)(L)
        OP_MOV    = 5'h11,   // mov rd, rs
        OP_MOV_L  = 5'h12,   // mov rd, L
        OP_STORE  = 5'h13,   // mov (rd)(L), rs
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1a,
        OP_SUBI   = 5'h1b,
        OP_MUL    = 5'h1c
    } opcode_t;

    // rd, rs and rt live in bits 26:22, 21:17 and 16:12
    typedef logic [4:0] reg_addr_t;

    typedef logic [11:0] imm_t;   // Literal L in bits 11:0

endpackage

/* tinker_core_pkg.sv */
// Internal types of the core with word and address widths taken from tinker_cfg.svh
`include "tinker_cfg.svh"

package tinker_core_pkg;

    typedef logic [`TINKER_XLEN-1:0] word_t;
    typedef logic [`TINKER_AW-1:0]   addr_t;

    // Immediate forms take zero-extended L as second operand
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_MUL,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOT,
        ALU_SHR, ALU_SHL,
        ALU_PASS,     // mov rd, rs
        ALU_INS_LO,   // L into bits 11:0
        ALU_ADDI, ALU_SUBI, ALU_SHRI, ALU_SHLI
    } alu_op_t;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_NONE
    } op_class_t;

    // Next-PC selection for branch class
    typedef enum logic [2:0] {
        BR_ABS,       // a
        BR_REL_REG,   // pc + a
        BR_REL_IMM,   // pc + sext(L)
        BR_NZ,        // b if a != 0
        BR_GT         // b if a > b, signed
    } br_kind_t;

endpackage

/* tinker_decode.sv */
`timescale 1ns/100ps
// Decode stage holding one instruction. instr_valid is dropped while busy and bad opcodes do nothing
module tinker_decode (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [31:0]                 instr,
    input  logic                        instr_valid,
    input  logic                        ex_valid,
    input  logic                        wb_valid,
    output logic                        busy,
    output logic                        dec_valid,
    output tinker_isa_pkg::reg_addr_t   rd,
    output tinker_isa_pkg::reg_addr_t   ra,
    output tinker_isa_pkg::reg_addr_t   rb,
    output tinker_isa_pkg::imm_t        imm,
    output tinker_core_pkg::op_class_t  op_class,
    output tinker_core_pkg::alu_op_t    alu_op,
    output tinker_core_pkg::br_kind_t   br_kind
);
    tinker_isa_pkg::opcode_t    opcode;
    tinker_isa_pkg::reg_addr_t  f_rd;
    tinker_isa_pkg::reg_addr_t  f_rs;
    tinker_isa_pkg::reg_addr_t  f_rt;
    tinker_isa_pkg::reg_addr_t  ra_n;
    tinker_isa_pkg::reg_addr_t  rb_n;
    tinker_core_pkg::op_class_t class_n;
    tinker_core_pkg::alu_op_t   alu_n;
    tinker_core_pkg::br_kind_t  br_n;
    logic                       accept;

    assign opcode = tinker_isa_pkg::opcode_t'(instr[31:27]);
    assign f_rd   = instr[26:22];
    assign f_rs   = instr[21:17];
    assign f_rt   = instr[16:12];
    assign busy   = dec_valid | ex_valid | wb_valid;   // One instruction in flight
    assign accept = instr_valid & ~busy;

    // Operation class, ALU op and branch kind
    always_comb begin
        class_n = tinker_core_pkg::CLS_ALU;
        alu_n   = tinker_core_pkg::ALU_PASS;
        br_n    = tinker_core_pkg::BR_ABS;
        case (opcode)
            tinker_isa_pkg::OP_ADD:    alu_n = tinker_core_pkg::ALU_ADD;
            tinker_isa_pkg::OP_ADDI:   alu_n = tinker_core_pkg::ALU_ADDI;
            tinker_isa_pkg::OP_SUB:    alu_n = tinker_core_pkg::ALU_SUB;
            tinker_isa_pkg::OP_SUBI:   alu_n = tinker_core_pkg::ALU_SUBI;
            tinker_isa_pkg::OP_MUL:    alu_n = tinker_core_pkg::ALU_MUL;
            tinker_isa_pkg::OP_AND:    alu_n = tinker_core_pkg::ALU_AND;
            tinker_isa_pkg::OP_OR:     alu_n = tinker_core_pkg::ALU_OR;
            tinker_isa_pkg::OP_XOR:    alu_n = tinker_core_pkg::ALU_XOR;
            tinker_isa_pkg::OP_NOT:    alu_n = tinker_core_pkg::ALU_NOT;
            tinker_isa_pkg::OP_SHFTR:  alu_n = tinker_core_pkg::ALU_SHR;
            tinker_isa_pkg::OP_SHFTRI: alu_n = tinker_core_pkg::ALU_SHRI;
            tinker_isa_pkg::OP_SHFTL:  alu_n = tinker_core_pkg::ALU_SHL;
            tinker_isa_pkg::OP_SHFTLI: alu_n = tinker_core_pkg::ALU_SHLI;
            tinker_isa_pkg::OP_MOV:    alu_n = tinker_core_pkg::ALU_PASS;
            tinker_isa_pkg::OP_MOV_L:  alu_n = tinker_core_pkg::ALU_INS_LO;
            tinker_isa_pkg::OP_LOAD:   class_n = tinker_core_pkg::CLS_LOAD;
            tinker_isa_pkg::OP_STORE:  class_n = tinker_core_pkg::CLS_STORE;
            tinker_isa_pkg::OP_BR,
            tinker_isa_pkg::OP_BRR_R,
            tinker_isa_pkg::OP_BRR_L,
            tinker_isa_pkg::OP_BRNZ,
            tinker_isa_pkg::OP_BRGT:   class_n = tinker_core_pkg::CLS_BRANCH;
            default:                   class_n = tinker_core_pkg::CLS_NONE;
        endcase
        case (opcode)
            tinker_isa_pkg::OP_BRR_R:  br_n = tinker_core_pkg::BR_REL_REG;
            tinker_isa_pkg::OP_BRR_L:  br_n = tinker_core_pkg::BR_REL_IMM;
            tinker_isa_pkg::OP_BRNZ:   br_n = tinker_core_pkg::BR_NZ;
            tinker_isa_pkg::OP_BRGT:   br_n = tinker_core_pkg::BR_GT;
            default:                   br_n = tinker_core_pkg::BR_ABS;
        endcase
    end

    // Read ports default to rs and rt
    always_comb begin
        ra_n = f_rs;
        rb_n = f_rt;
        case (opcode)
            tinker_isa_pkg::OP_ADDI, tinker_isa_pkg::OP_SUBI,
            tinker_isa_pkg::OP_SHFTRI, tinker_isa_pkg::OP_SHFTLI,
            tinker_isa_pkg::OP_MOV_L,
            tinker_isa_pkg::OP_BR, tinker_isa_pkg::OP_BRR_R:
                ra_n = f_rd;
            tinker_isa_pkg::OP_BRNZ, tinker_isa_pkg::OP_BRGT:
                rb_n = f_rd;   // Branch target
            tinker_isa_pkg::OP_STORE: begin
                ra_n = f_rd;   // Base
                rb_n = f_rs;   // Value
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rd       <= f_rd;
            ra       <= ra_n;
            rb       <= rb_n;
            imm      <= instr[11:0];
            op_class <= class_n;
            alu_op   <= alu_n;
            br_kind  <= br_n;
        end
    end

endmodule

/* tinker_regfile.sv */
`timescale 1ns/100ps
// Register file with combinational reads. Writes land on the clock edge so a same-cycle read sees old data
`include "tinker_cfg.svh"

module tinker_regfile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       we,
    input  tinker_isa_pkg::reg_addr_t  waddr,
    input  tinker_core_pkg::word_t     wdata,
    input  tinker_isa_pkg::reg_addr_t  ra,
    input  tinker_isa_pkg::reg_addr_t  rb,
    output tinker_core_pkg::word_t     a_data,
    output tinker_core_pkg::word_t     b_data
);
    tinker_core_pkg::word_t regs [`TINKER_NREGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_NREGS; i++) begin
                regs[i] <= '0;
            end
            regs[`TINKER_NREGS-1] <= `TINKER_STACK_INIT;   // r31 is the stack pointer
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign a_data = regs[ra];
    assign b_data = regs[rb];

endmodule

/* tinker_execute.sv */
`timescale 1ns/100ps
// Execute stage and PC owner. The PC steps only for a valid instruction and brgt compares rs with rd
`include "tinker_cfg.svh"

module tinker_execute (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        dec_valid,
    input  tinker_isa_pkg::reg_addr_t   rd,
    input  tinker_isa_pkg::imm_t        imm,
    input  tinker_core_pkg::op_class_t  op_class,
    input  tinker_core_pkg::alu_op_t    alu_op,
    input  tinker_core_pkg::br_kind_t   br_kind,
    input  tinker_core_pkg::word_t      a_data,
    input  tinker_core_pkg::word_t      b_data,
    output logic                        ex_valid,
    output tinker_core_pkg::op_class_t  ex_class,
    output tinker_isa_pkg::reg_addr_t   ex_rd,
    output tinker_core_pkg::word_t      ex_result,
    output tinker_core_pkg::addr_t      ex_addr,
    output tinker_core_pkg::word_t      ex_store_data,
    output tinker_core_pkg::addr_t      pc
);
    tinker_core_pkg::word_t imm_zext;
    tinker_core_pkg::word_t alu_res;
    tinker_core_pkg::addr_t a_addr;
    tinker_core_pkg::addr_t b_addr;
    tinker_core_pkg::addr_t pc_next;

    assign imm_zext = tinker_core_pkg::word_t'(imm);
    assign a_addr   = a_data[`TINKER_AW-1:0];
    assign b_addr   = b_data[`TINKER_AW-1:0];

    always_comb begin
        case (alu_op)
            tinker_core_pkg::ALU_ADD:    alu_res = a_data + b_data;
            tinker_core_pkg::ALU_ADDI:   alu_res = a_data + imm_zext;
            tinker_core_pkg::ALU_SUB:    alu_res = a_data - b_data;
            tinker_core_pkg::ALU_SUBI:   alu_res = a_data - imm_zext;
            tinker_core_pkg::ALU_MUL:    alu_res = a_data * b_data;   // Low 64 bits
            tinker_core_pkg::ALU_AND:    alu_res = a_data & b_data;
            tinker_core_pkg::ALU_OR:     alu_res = a_data | b_data;
            tinker_core_pkg::ALU_XOR:    alu_res = a_data ^ b_data;
            tinker_core_pkg::ALU_NOT:    alu_res = ~a_data;
            tinker_core_pkg::ALU_SHR:    alu_res = a_data >> b_data;  // Logical
            tinker_core_pkg::ALU_SHRI:   alu_res = a_data >> imm;
            tinker_core_pkg::ALU_SHL:    alu_res = a_data << b_data;
            tinker_core_pkg::ALU_SHLI:   alu_res = a_data << imm;
            tinker_core_pkg::ALU_INS_LO: alu_res = {a_data[`TINKER_XLEN-1:12], imm};
            default:                     alu_res = a_data;
        endcase
    end

    // Offsets are relative to this instruction's own PC
    always_comb begin
        pc_next = pc + tinker_core_pkg::addr_t'(4);
        if (op_class == tinker_core_pkg::CLS_BRANCH) begin
            case (br_kind)
                tinker_core_pkg::BR_ABS:     pc_next = a_addr;
                tinker_core_pkg::BR_REL_REG: pc_next = pc + a_addr;
                tinker_core_pkg::BR_REL_IMM: pc_next = pc + tinker_core_pkg::addr_t'(signed'(imm));
                tinker_core_pkg::BR_NZ: begin
                    if (a_data != '0) begin
                        pc_next = b_addr;
                    end
                end
                tinker_core_pkg::BR_GT: begin
                    if ($signed(a_data) > $signed(b_data)) begin
                        pc_next = b_addr;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid <= 1'b0;
            pc       <= `TINKER_RESET_PC;
        end else begin
            ex_valid <= dec_valid;
            if (dec_valid) begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_class      <= op_class;
            ex_rd         <= rd;
            ex_result     <= alu_res;
            ex_addr       <= a_addr + tinker_core_pkg::addr_t'(imm);   // Base + zext(L)
            ex_store_data <= b_data;
        end
    end

endmodule

/* tinker_memory.sv */
`timescale 1ns/100ps
// Memory stage with word-addressed data RAM. Byte addresses drop bits 2:0 and wrap at the RAM depth
`include "tinker_cfg.svh"

module tinker_memory (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ex_valid,
    input  tinker_core_pkg::op_class_t  ex_class,
    input  tinker_isa_pkg::reg_addr_t   ex_rd,
    input  tinker_core_pkg::word_t      ex_result,
    input  tinker_core_pkg::addr_t      ex_addr,
    input  tinker_core_pkg::word_t      ex_store_data,
    output logic                        wb_valid,
    output tinker_isa_pkg::reg_addr_t   wb_reg,
    output tinker_core_pkg::word_t      wb_data
);
    localparam int IDX_W = $clog2(`TINKER_DMEM_WORDS);

    tinker_core_pkg::word_t dmem [`TINKER_DMEM_WORDS];
    logic [IDX_W-1:0]       idx;
    logic                   writes_reg;

    assign idx        = ex_addr[3 +: IDX_W];   // 8-byte words
    assign writes_reg = (ex_class == tinker_core_pkg::CLS_ALU) ||
                        (ex_class == tinker_core_pkg::CLS_LOAD);

    always_ff @(posedge clk) begin
        if (ex_valid && ex_class == tinker_core_pkg::CLS_STORE) begin
            dmem[idx] <= ex_store_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid & writes_reg;   // Stores and branches write nothing
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_reg  <= ex_rd;
            wb_data <= (ex_class == tinker_core_pkg::CLS_LOAD) ? dmem[idx] : ex_result;
        end
    end

endmodule

/* tinker_core.sv */
`timescale 1ns/100ps
// Tinker integer core top. Instructions come from outside and only one is in flight at a time
module tinker_core (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [31:0]                instr,
    input  logic                       instr_valid,
    output logic                       busy,
    output tinker_core_pkg::addr_t     pc,
    output logic                       wb_valid,
    output tinker_isa_pkg::reg_addr_t  wb_reg,
    output tinker_core_pkg::word_t     wb_data
);
    // Decode to execute
    logic                       dec_valid;
    tinker_isa_pkg::reg_addr_t  rd;
    tinker_isa_pkg::reg_addr_t  ra;
    tinker_isa_pkg::reg_addr_t  rb;
    tinker_isa_pkg::imm_t       imm;
    tinker_core_pkg::op_class_t op_class;
    tinker_core_pkg::alu_op_t   alu_op;
    tinker_core_pkg::br_kind_t  br_kind;

    tinker_core_pkg::word_t     a_data;   // Regfile read data
    tinker_core_pkg::word_t     b_data;

    // Execute to memory
    logic                       ex_valid;
    tinker_core_pkg::op_class_t ex_class;
    tinker_isa_pkg::reg_addr_t  ex_rd;
    tinker_core_pkg::word_t     ex_result;
    tinker_core_pkg::addr_t     ex_addr;
    tinker_core_pkg::word_t     ex_store_data;

    tinker_decode i_tinker_decode (.*);

    // wb_valid only rises for register-writing instructions
    tinker_regfile i_tinker_regfile (
        .we    (wb_valid),
        .waddr (wb_reg),
        .wdata (wb_data),
        .*
    );

    tinker_execute i_tinker_execute (.*);

    tinker_memory i_tinker_memory (.*);

endmodule

/* tb_tinker.sv */
// Plays a table of instructions one at a time. Expects writeback 3 cycles after acceptance
`timescale 1ns/100ps
`include "tinker_cfg.svh"

module tb_tinker;

    typedef struct packed {
        logic [31:0] instr;
        logic        wb_exp;   // Writeback expected
        logic [4:0]  wb_reg;
        logic [63:0] wb_data;
        logic [31:0] pc;       // PC after the instruction
        logic        hold;     // Keep instr_valid high for a second cycle
    } row_t;

    logic                       clk = 1'b0;
    logic                       reset;
    logic [31:0]                instr;
    logic                       instr_valid;
    logic                       busy;
    tinker_core_pkg::addr_t     pc;
    logic                       wb_valid;
    tinker_isa_pkg::reg_addr_t  wb_reg;
    tinker_core_pkg::word_t     wb_data;

    row_t rows[$];
    int   errors      = 0;
    int   wb_count    = 0;
    int   expected_wb = 0;
    logic table_ready = 1'b0;

    tinker_core i_tinker_core (.*);

    always #5 clk = ~clk;

    // Every writeback pulse, including any from a dropped instruction
    always @(negedge clk) begin
        if (wb_valid) begin
            wb_count++;
        end
    end

    function automatic logic [31:0] encode(input tinker_isa_pkg::opcode_t op, input int rd,
                                           input int rs, input int rt, input int lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), 12'(lit)};
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic push_row(input logic [31:0] ins, input logic wb, input int rd,
                            input logic [63:0] data, input logic [31:0] next_pc,
                            input logic hold);
        row_t r;
        r.instr   = ins;
        r.wb_exp  = wb;
        r.wb_reg  = 5'(rd);
        r.wb_data = data;
        r.pc      = next_pc;
        r.hold    = hold;
        rows.push_back(r);
        if (wb) begin
            expected_wb++;
        end
    endtask

    task automatic wb_row(input logic [31:0] ins, input int rd, input logic [63:0] data,
                          input logic [31:0] next_pc);
        push_row(ins, 1'b1, rd, data, next_pc, 1'b0);
    endtask

    task automatic quiet_row(input logic [31:0] ins, input logic [31:0] next_pc);
        push_row(ins, 1'b0, 0, 64'h0, next_pc, 1'b0);
    endtask

    task automatic held_wb_row(input logic [31:0] ins, input int rd, input logic [63:0] data,
                               input logic [31:0] next_pc);
        push_row(ins, 1'b1, rd, data, next_pc, 1'b1);
    endtask

    task automatic build_table();
        // r31 comes out of reset as the stack pointer
        wb_row(encode(tinker_isa_pkg::OP_MOV, 1, 31, 0, 0), 1, 64'h10000, 32'h2004);
        // Operands
        wb_row(encode(tinker_isa_pkg::OP_MOV_L, 2, 0, 0, 'h123), 2, 64'h123, 32'h2008);
        wb_row(encode(tinker_isa_pkg::OP_MOV_L, 3, 0, 0, 'hfff), 3, 64'hfff, 32'h200c);
        wb_row(encode(tinker_isa_pkg::OP_SHFTLI, 3, 0, 0, 'h00c), 3, 64'hfff000, 32'h2010);
        wb_row(encode(tinker_isa_pkg::OP_MOV_L, 3, 0, 0, 'habc), 3, 64'hfffabc, 32'h2014);
        // ALU operations
        wb_row(encode(tinker_isa_pkg::OP_ADD, 4, 2, 3, 0), 4, 64'hfffbdf, 32'h2018);
        wb_row(encode(tinker_isa_pkg::OP_ADDI, 2, 0, 0, 'h010), 2, 64'h133, 32'h201c);
        wb_row(encode(tinker_isa_pkg::OP_SUB, 5, 2, 3, 0), 5, 64'hffff_ffff_ff00_0677, 32'h2020);
        wb_row(encode(tinker_isa_pkg::OP_SUBI, 2, 0, 0, 'h033), 2, 64'h100, 32'h2024);
        wb_row(encode(tinker_isa_pkg::OP_MUL, 6, 2, 3, 0), 6, 64'hfffabc00, 32'h2028);
        wb_row(encode(tinker_isa_pkg::OP_AND, 7, 3, 4, 0), 7, 64'hfffa9c, 32'h202c);
        wb_row(encode(tinker_isa_pkg::OP_OR, 8, 3, 4, 0), 8, 64'hfffbff, 32'h2030);
        wb_row(encode(tinker_isa_pkg::OP_XOR, 9, 3, 4, 0), 9, 64'h163, 32'h2034);
        wb_row(encode(tinker_isa_pkg::OP_NOT, 10, 3, 0, 0), 10, 64'hffff_ffff_ff00_0543, 32'h2038);
        wb_row(encode(tinker_isa_pkg::OP_MOV_L, 12, 0, 0, 'h004), 12, 64'h4, 32'h203c);
        wb_row(encode(tinker_isa_pkg::OP_SHFTR, 11, 3, 12, 0), 11, 64'hfffab, 32'h2040);
        wb_row(encode(tinker_isa_pkg::OP_SHFTL, 13, 3, 12, 0), 13, 64'hfffabc0, 32'h2044);
        wb_row(encode(tinker_isa_pkg::OP_SHFTRI, 3, 0, 0, 'h008), 3, 64'hfffa, 32'h2048);
        // Store r4 to 0x128, load back from 0x12c in the same 8-byte word
        wb_row(encode(tinker_isa_pkg::OP_MOV_L, 14, 0, 0, 'h100), 14, 64'h100, 32'h204c);
        quiet_row(encode(tinker_isa_pkg::OP_STORE, 14, 4, 0, 'h028), 32'h2050);
        wb_row(encode(tinker_isa_pkg::OP_LOAD, 15, 14, 0, 'h02c), 15, 64'hfffbdf, 32'h2054);
        // Branches
        wb_row(encode(tinker_isa_pkg::OP_MOV_L, 16, 0, 0, 'h400), 16, 64'h400, 32'h2058);
        wb_row(encode(tinker_isa_pkg::OP_SHFTLI, 16, 0, 0, 'h004), 16, 64'h4000, 32'h205c);
        quiet_row(encode(tinker_isa_pkg::OP_BR, 16, 0, 0, 0), 32'h4000);
        quiet_row(encode(tinker_isa_pkg::OP_BRR_R, 2, 0, 0, 0), 32'h4100);
        quiet_row(encode(tinker_isa_pkg::OP_BRR_L, 0, 0, 0, 'h020), 32'h4120);
        quiet_row(encode(tinker_isa_pkg::OP_BRR_L, 0, 0, 0, 'hff0), 32'h4110);   // -16
        quiet_row(encode(tinker_isa_pkg::OP_BRNZ, 16, 12, 0, 0), 32'h4000);      // Taken
        quiet_row(encode(tinker_isa_pkg::OP_BRNZ, 16, 0, 0, 0), 32'h4004);       // r0 is zero
        wb_row(encode(tinker_isa_pkg::OP_MOV_L, 17, 0, 0, 'h300), 17, 64'h300, 32'h4008);
        quiet_row(encode(tinker_isa_pkg::OP_BRGT, 17, 16, 0, 0), 32'h300);
        // Negative r5 against 0x300 must not branch
        quiet_row(encode(tinker_isa_pkg::OP_BRGT, 17, 5, 0, 0), 32'h304);
        // Second pulse while busy is dropped
        wb_row(encode(tinker_isa_pkg::OP_MOV_L, 18, 0, 0, 'h055), 18, 64'h55, 32'h308);
        held_wb_row(encode(tinker_isa_pkg::OP_ADDI, 18, 0, 0, 'h001), 18, 64'h56, 32'h30c);
        wb_row(encode(tinker_isa_pkg::OP_MOV, 19, 18, 0, 0), 19, 64'h56, 32'h310);
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic play_row(input row_t r);
        wait_idle();
        instr       = r.instr;
        instr_valid = 1'b1;
        @(posedge clk);   // Accepted here
        #1;
        check("busy", 64'(busy), 64'h1);   // Decode holds it
        if (!r.hold) begin
            instr_valid = 1'b0;
        end
        @(posedge clk);
        #1;
        check("busy", 64'(busy), 64'h1);   // Execute holds it
        instr_valid = 1'b0;
        @(posedge clk);
        #1;
        check("wb_valid", 64'(wb_valid), 64'(r.wb_exp));
        // Only a writeback keeps the core busy now
        check("busy", 64'(busy), 64'(r.wb_exp));
        if (r.wb_exp) begin
            check("wb_reg", 64'(wb_reg), 64'(r.wb_reg));
            check("wb_data", wb_data, r.wb_data);
        end
        check("pc", 64'(pc), 64'(r.pc));
    endtask

    initial begin
        wait (table_ready);
        repeat (rows.size() * 8 + 20) @(posedge clk);
        $display("Timeout: the core did not get through the instruction table in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check("pc", 64'(pc), 64'(`TINKER_RESET_PC));
        check("busy", 64'(busy), 64'h0);
        check("wb_valid", 64'(wb_valid), 64'h0);
        foreach (rows[i]) begin
            play_row(rows[i]);
        end
        wait_idle();
        repeat (4) @(posedge clk);   // Room for a stray writeback
        #1;
        check("wb_count", 64'(wb_count), 64'(expected_wb));
        $display("Errors: %0d, writebacks: %0d of %0d", errors, wb_count, expected_wb);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
tinker_isa_pkg.sv
tinker_core_pkg.sv
tinker_decode.sv
tinker_regfile.sv
tinker_execute.sv
tinker_memory.sv
tinker_core.sv
tb_tinker.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_tinker
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure, see $(LOG)"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
